// ==== wb_sram_top.f ====
design/wb_bus_pkg.sv
design/sram_macro_pkg.sv
design/wb_port_control.sv
design/wb_latency_regs.sv
design/wb_bank_decode.sv
design/wb_sram_top.sv
test/sram_macro_model.sv
test/tb_wb_sram.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    -f wb_sram_top.f \
    --top-module tb_wb_sram \
    -o tb_wb_sram

./obj_dir/tb_wb_sram | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== test/wb_sram_trace.txt ====
# columns: test id, op (R or W), byte address, write data, expected read data
# values in hex except the test id, expected data is ignored for writes
1 R 800 00000000 00000001
1 R 804 00000000 00000002
2 W 010 12345678 00000000
2 W 3fc cafef00d 00000000
2 R 010 00000000 12345678
2 R 3fc 00000000 cafef00d
3 R 404 00000000 a0000001
3 R 7fc 00000000 a00000ff
3 W 408 deadbeef 00000000
3 R 408 00000000 a0000002
4 W 800 00000000 00000000
4 W 804 00000000 00000000
4 R 800 00000000 00000000
4 R 010 00000000 12345678
4 R 404 00000000 a0000001
4 W 800 0000000f 00000000
4 W 804 0000000f 00000000
4 R 800 00000000 0000000f
4 R 804 00000000 0000000f
4 R 3fc 00000000 cafef00d
4 R 7fc 00000000 a00000ff
5 R c00 00000000 00000000
5 W c04 ffffffff 00000000
5 R 010 00000000 12345678

// ==== test/tb_wb_sram.sv ====
`timescale 1ns/1ps

module tb_wb_sram;
    import wb_bus_pkg::*;
    import sram_macro_pkg::*;

    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 2;
    localparam int    MAX_LATENCY  = 15;
    localparam int    OP_OVERHEAD  = 8;
    localparam string TRACE_FILE   = "test/wb_sram_trace.txt";

    logic       wb_clk;
    logic       wb_rst;
    wb_req_t    req;
    wb_rsp_t    rsp;
    sram_ctrl_t ram0_ctrl;
    sram_ctrl_t ram1_ctrl;
    wb_data_t   ram0_din;
    wb_data_t   ram0_dout;
    wb_data_t   ram1_dout;

    // Trace contents, one entry per operation
    int         op_id[$];
    logic [7:0] op_kind[$];
    wb_addr_t   op_addr[$];
    wb_data_t   op_wdata[$];
    wb_data_t   op_expect[$];

    int mismatches;
    int tests_passed;
    int tests_failed;
    bit trace_loaded;

    wb_sram_top i_dut (
        .wb_clk_i    (wb_clk),
        .wb_rst_i    (wb_rst),
        .req_i       (req),
        .ram0_dout_i (ram0_dout),
        .ram1_dout_i (ram1_dout),
        .rsp_o       (rsp),
        .ram0_ctrl_o (ram0_ctrl),
        .ram1_ctrl_o (ram1_ctrl),
        .ram0_din_o  (ram0_din)
    );

    // Bank 0 starts blank
    sram_macro_model #(
        .PRELOAD      (1'b0),
        .PRELOAD_BASE (32'h0)
    ) i_ram0 (
        .ctrl_i (ram0_ctrl),
        .din_i  (ram0_din),
        .dout_o (ram0_dout)
    );

    // Bank 1 ROM image, never written
    sram_macro_model #(
        .PRELOAD      (1'b1),
        .PRELOAD_BASE (32'hA000_0000)
    ) i_ram1 (
        .ctrl_i (ram1_ctrl),
        .din_i  (32'h0),
        .dout_o (ram1_dout)
    );

    initial begin
        wb_clk = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
    end

    task automatic check_value(input wb_data_t got, input wb_data_t expected, input string msg);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s: got %08h, expected %08h", $time, msg, got, expected);
            mismatches++;
        end
    endtask

    task automatic load_trace(output bit ok);
        int         fd;
        int         n;
        int         id;
        logic [7:0] kind;
        wb_addr_t   addr;
        wb_data_t   wdata;
        wb_data_t   expected;
        string      line;
        ok = 1'b0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                // Column notes start with a hash
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %c %h %h %h", id, kind, addr, wdata, expected);
                    if (n == 5) begin
                        op_id.push_back(id);
                        op_kind.push_back(kind);
                        op_addr.push_back(addr);
                        op_wdata.push_back(wdata);
                        op_expect.push_back(expected);
                    end
                end
            end
            $fclose(fd);
            ok = (op_id.size() > 0);
        end
    endtask

    task automatic run_op(input int idx);
        wb_req_t next_req;
        string   msg;
        int      gap;
        next_req.cyc = 1'b1;
        next_req.stb = 1'b1;
        next_req.we  = (op_kind[idx] == "W");
        next_req.adr = op_addr[idx];
        next_req.dat = op_wdata[idx];
        msg = $sformatf("test %0d %c %03h", op_id[idx], op_kind[idx], op_addr[idx]);
        @(posedge wb_clk);
        req <= next_req;
        // Latency set by target and registers, watchdog bounds it
        @(posedge wb_clk);
        while (!rsp.ack) begin
            @(posedge wb_clk);
        end
        // Write data on the response is don't care
        if (op_kind[idx] == "R") begin
            check_value(rsp.dat, op_expect[idx], msg);
        end
        req <= '0;
        // Ack must follow stb down within a cycle
        @(posedge wb_clk);
        check_value(wb_data_t'(rsp.ack), 32'h0, {msg, " ack after stb drop"});
        gap = int'($urandom % 4);
        repeat (gap) @(posedge wb_clk);
    endtask

    task automatic report_test(input int id, input int errors, input int ops);
        if (errors == 0) begin
            $display("test %0d passed, %0d operations", id, ops);
            tests_passed++;
        end else begin
            $display("test %0d failed, %0d mismatches", id, errors);
            tests_failed++;
        end
    endtask

    initial begin
        bit ok;
        int cur_id;
        int first_err;
        int ops;
        wb_rst <= 1'b1;
        req    <= '0;
        trace_loaded = 1'b0;
        mismatches   = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(32'h3ed8_2b32));
        load_trace(ok);
        if (!ok) begin
            $display("ERROR: trace file %s is missing or holds no operations", TRACE_FILE);
            $display("TEST FAILED");
            $finish;
        end else begin
            trace_loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge wb_clk);
            wb_rst <= 1'b0;
            cur_id    = op_id[0];
            first_err = 0;
            ops       = 0;
            foreach (op_id[i]) begin
                // New test id closes the previous test
                if (op_id[i] != cur_id) begin
                    report_test(cur_id, mismatches - first_err, ops);
                    cur_id    = op_id[i];
                    first_err = mismatches;
                    ops       = 0;
                end
                run_op(i);
                ops++;
            end
            report_test(cur_id, mismatches - first_err, ops);
            $display("summary: %0d tests passed, %0d tests failed, %0d mismatches",
                     tests_passed, tests_failed, mismatches);
            if (tests_failed == 0 && mismatches == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    // Worst case per operation is two full latencies plus bus overhead
    initial begin
        longint limit_ns;
        wait (trace_loaded);
        limit_ns = longint'(op_id.size()) * (2 * MAX_LATENCY + OP_OVERHEAD) * CLK_PERIOD
                 + RESET_CYCLES * CLK_PERIOD;
        #(limit_ns);
        $display("ERROR: timeout after %0d ns, an acknowledge never came", limit_ns);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== test/sram_macro_model.sv ====
`timescale 1ns/1ps

module sram_macro_model #(
    parameter bit          PRELOAD      = 1'b0,
    parameter logic [31:0] PRELOAD_BASE = 32'h0
) (
    input  sram_macro_pkg::sram_ctrl_t ctrl_i,
    input  wb_bus_pkg::wb_data_t       din_i,
    output wb_bus_pkg::wb_data_t       dout_o
);
    import wb_bus_pkg::*;
    import sram_macro_pkg::*;

    wb_data_t mem [256];
    logic     ram_clk;

    // Stretched clock from the port control
    assign ram_clk = ctrl_i.clk;

    // Image is base plus word address, or all zero
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] <= PRELOAD ? PRELOAD_BASE + 32'(i) : 32'h0;
        end
        dout_o <= 32'h0;
    end

    // Inputs latched on the rising macro clock while selected
    always @(posedge ram_clk) begin
        if (!ctrl_i.csb) begin
            if (!ctrl_i.web) begin
                mem[ctrl_i.addr] <= din_i;
            end else begin
                // Read data holds until the next read
                dout_o <= mem[ctrl_i.addr];
            end
        end
    end

endmodule

// ==== design/wb_sram_top.sv ====
`timescale 1ns/1ps

module wb_sram_top #(
    parameter int LATENCY_W    = 4,
    parameter int PREFETCH_RST = 1,
    parameter int READ_RST     = 2
) (
    input  logic                      wb_clk_i,
    input  logic                      wb_rst_i,
    input  wb_bus_pkg::wb_req_t       req_i,
    input  wb_bus_pkg::wb_data_t      ram0_dout_i,
    input  wb_bus_pkg::wb_data_t      ram1_dout_i,
    output wb_bus_pkg::wb_rsp_t       rsp_o,
    output sram_macro_pkg::sram_ctrl_t ram0_ctrl_o,
    output sram_macro_pkg::sram_ctrl_t ram1_ctrl_o,
    output wb_bus_pkg::wb_data_t      ram0_din_o
);
    import wb_bus_pkg::*;
    import sram_macro_pkg::*;

    wb_req_t              bank0_req;
    wb_req_t              bank1_req;
    wb_req_t              regs_req;
    wb_rsp_t              bank0_rsp;
    wb_rsp_t              bank1_rsp;
    wb_rsp_t              regs_rsp;
    logic [LATENCY_W-1:0] prefetch_cycles;
    logic [LATENCY_W-1:0] read_cycles;
    logic                 ram0_clk;
    logic                 ram0_csb;
    logic                 ram0_web;
    logic                 ram1_clk;
    logic                 ram1_csb;
    logic                 ram1_web;
    sram_addr_t           word_addr;

    // Address and strobe split per target
    wb_bank_decode i_decode (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .req_i       (req_i),
        .bank0_rsp_i (bank0_rsp),
        .bank1_rsp_i (bank1_rsp),
        .regs_rsp_i  (regs_rsp),
        .bank0_req_o (bank0_req),
        .bank1_req_o (bank1_req),
        .regs_req_o  (regs_req),
        .rsp_o       (rsp_o)
    );

    // Latencies shared by both banks
    wb_latency_regs #(
        .LATENCY_W    (LATENCY_W),
        .PREFETCH_RST (PREFETCH_RST),
        .READ_RST     (READ_RST)
    ) i_regs (
        .wb_clk_i          (wb_clk_i),
        .wb_rst_i          (wb_rst_i),
        .req_i             (regs_req),
        .rsp_o             (regs_rsp),
        .prefetch_cycles_o (prefetch_cycles),
        .read_cycles_o     (read_cycles)
    );

    // Bank 0 read/write
    wb_port_control #(
        .LATENCY_W (LATENCY_W),
        .READ_ONLY (1'b0)
    ) i_port0 (
        .wb_clk_i          (wb_clk_i),
        .wb_rst_i          (wb_rst_i),
        .req_i             (bank0_req),
        .prefetch_cycles_i (prefetch_cycles),
        .read_cycles_i     (read_cycles),
        .ram_dout_i        (ram0_dout_i),
        .rsp_o             (bank0_rsp),
        .ram_clk_o         (ram0_clk),
        .ram_csb_o         (ram0_csb),
        .ram_web_o         (ram0_web)
    );

    // Bank 1 ROM image
    wb_port_control #(
        .LATENCY_W (LATENCY_W),
        .READ_ONLY (1'b1)
    ) i_port1 (
        .wb_clk_i          (wb_clk_i),
        .wb_rst_i          (wb_rst_i),
        .req_i             (bank1_req),
        .prefetch_cycles_i (prefetch_cycles),
        .read_cycles_i     (read_cycles),
        .ram_dout_i        (ram1_dout_i),
        .rsp_o             (bank1_rsp),
        .ram_clk_o         (ram1_clk),
        .ram_csb_o         (ram1_csb),
        .ram_web_o         (ram1_web)
    );

    // Word address straight from the held request
    assign word_addr = req_i.adr[9:2];

    assign ram0_ctrl_o = '{clk: ram0_clk, csb: ram0_csb, web: ram0_web, addr: word_addr};
    assign ram1_ctrl_o = '{clk: ram1_clk, csb: ram1_csb, web: ram1_web, addr: word_addr};
    assign ram0_din_o  = req_i.dat;

endmodule

// ==== design/wb_bank_decode.sv ====
`timescale 1ns/1ps

module wb_bank_decode (
    input  logic                wb_clk_i,
    input  logic                wb_rst_i,
    input  wb_bus_pkg::wb_req_t req_i,
    input  wb_bus_pkg::wb_rsp_t bank0_rsp_i,
    input  wb_bus_pkg::wb_rsp_t bank1_rsp_i,
    input  wb_bus_pkg::wb_rsp_t regs_rsp_i,
    output wb_bus_pkg::wb_req_t bank0_req_o,
    output wb_bus_pkg::wb_req_t bank1_req_o,
    output wb_bus_pkg::wb_req_t regs_req_o,
    output wb_bus_pkg::wb_rsp_t rsp_o
);
    import wb_bus_pkg::*;

    wb_region_t region;
    logic       sel_bank0;
    logic       sel_bank1;
    logic       sel_regs;
    logic       sel_unmapped;
    logic       unmapped_ack_r;
    logic       unmapped_ack;

    // Region from the top two address bits
    assign region       = req_i.adr[11:10];
    assign sel_bank0    = (region == ADDR_BANK0_BASE);
    assign sel_bank1    = (region == ADDR_BANK1_BASE);
    assign sel_regs     = (region == ADDR_REGS_BASE);
    assign sel_unmapped = (region == ADDR_UNMAPPED);

    // Full request to every target
    // strobe only to the selected one
    always_comb begin
        bank0_req_o     = req_i;
        bank0_req_o.stb = req_i.stb && sel_bank0;
        bank1_req_o     = req_i;
        bank1_req_o.stb = req_i.stb && sel_bank1;
        regs_req_o      = req_i;
        regs_req_o.stb  = req_i.stb && sel_regs;
    end

    // Self ack for the unmapped region
    // keeps a stray address from hanging the bus
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            unmapped_ack_r <= 1'b0;
        end else begin
            unmapped_ack_r <= req_i.cyc && req_i.stb && sel_unmapped && !unmapped_ack_r;
        end
    end

    assign unmapped_ack = unmapped_ack_r && req_i.cyc && req_i.stb && sel_unmapped;

    // Idle targets return all zero, so a plain OR merges them
    // Unmapped access contributes ack only, data stays zero
    assign rsp_o.ack = bank0_rsp_i.ack | bank1_rsp_i.ack | regs_rsp_i.ack | unmapped_ack;
    assign rsp_o.dat = bank0_rsp_i.dat | bank1_rsp_i.dat | regs_rsp_i.dat;

endmodule

// ==== design/wb_latency_regs.sv ====
`timescale 1ns/1ps

module wb_latency_regs #(
    parameter int LATENCY_W    = 4,
    parameter int PREFETCH_RST = 1,
    parameter int READ_RST     = 2
) (
    input  logic                 wb_clk_i,
    input  logic                 wb_rst_i,
    input  wb_bus_pkg::wb_req_t  req_i,
    output wb_bus_pkg::wb_rsp_t  rsp_o,
    output logic [LATENCY_W-1:0] prefetch_cycles_o,
    output logic [LATENCY_W-1:0] read_cycles_o
);
    import wb_bus_pkg::*;

    logic [LATENCY_W-1:0] prefetch_r;
    logic [LATENCY_W-1:0] read_r;
    logic                 ack_r;
    wb_data_t             dat_r;
    logic                 req_valid;
    logic                 access;
    logic                 sel_read;

    assign req_valid = req_i.cyc && req_i.stb;
    // One access per strobe, the ack cycle itself is not a new access
    assign access    = req_valid && !ack_r;
    // Word 0 prefetch, word 1 read
    assign sel_read  = req_i.adr[2];

    // Single cycle ack, dropped as soon as the host sees it
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ack_r <= 1'b0;
        end else begin
            ack_r <= access;
        end
    end

    // Latency registers
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            prefetch_r <= LATENCY_W'(PREFETCH_RST);
            read_r     <= LATENCY_W'(READ_RST);
        end else if (access && req_i.we) begin
            if (sel_read) begin
                read_r <= req_i.dat[LATENCY_W-1:0];
            end else begin
                prefetch_r <= req_i.dat[LATENCY_W-1:0];
            end
        end
    end

    // Read data sampled before the write lands
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            dat_r <= sel_read ? wb_data_t'(read_r) : wb_data_t'(prefetch_r);
        end
    end

    assign rsp_o.ack = ack_r && req_valid;
    assign rsp_o.dat = (ack_r && req_valid) ? dat_r : '0;

    assign prefetch_cycles_o = prefetch_r;
    assign read_cycles_o     = read_r;

endmodule

// ==== design/wb_port_control.sv ====
`timescale 1ns/1ps

module wb_port_control #(
    parameter int LATENCY_W = 4,
    parameter bit READ_ONLY = 1'b0
) (
    input  logic                 wb_clk_i,
    input  logic                 wb_rst_i,
    input  wb_bus_pkg::wb_req_t  req_i,
    input  logic [LATENCY_W-1:0] prefetch_cycles_i,
    input  logic [LATENCY_W-1:0] read_cycles_i,
    input  wb_bus_pkg::wb_data_t ram_dout_i,
    output wb_bus_pkg::wb_rsp_t  rsp_o,
    output logic                 ram_clk_o,
    output logic                 ram_csb_o,
    output logic                 ram_web_o
);
    import wb_bus_pkg::*;
    import sram_macro_pkg::*;

    port_state_e          state_r;
    logic [LATENCY_W-1:0] cycle_r;
    logic                 int_clk_r;
    logic                 csb_r;
    wb_data_t             dout_r;
    logic                 req_valid;
    logic                 ack;

    assign req_valid = req_i.cyc && req_i.stb;

    // Sequencer runs on the falling edge
    // so the stretched clock edges land mid bus cycle
    always_ff @(negedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_r   <= IDLE;
            cycle_r   <= '0;
            int_clk_r <= 1'b0;
        end else begin
            case (state_r)
                IDLE: begin
                    if (req_valid) begin
                        // Writes to a ROM bank never reach the macro
                        if (req_i.we && READ_ONLY) begin
                            state_r <= ACK;
                        end else begin
                            state_r <= ACTIVATE;
                        end
                    end
                end
                ACTIVATE: begin
                    // Macro clock rises here, csb already low
                    state_r   <= PREFETCH;
                    cycle_r   <= prefetch_cycles_i;
                    int_clk_r <= 1'b1;
                end
                PREFETCH: begin
                    if (cycle_r != '0) begin
                        cycle_r <= cycle_r - 1'b1;
                    end else begin
                        // Clock drops for the read phase
                        state_r   <= READWRITE;
                        cycle_r   <= read_cycles_i;
                        int_clk_r <= 1'b0;
                    end
                end
                READWRITE: begin
                    if (cycle_r != '0) begin
                        cycle_r <= cycle_r - 1'b1;
                    end else begin
                        state_r <= ACK;
                    end
                end
                ACK: begin
                    // Hold until the host lets go of the strobe
                    if (!req_valid) begin
                        state_r <= IDLE;
                    end
                end
                default: begin
                    state_r <= IDLE;
                end
            endcase
        end
    end

    // Capture macro output at the end of the read phase
    always_ff @(negedge wb_clk_i) begin
        if (state_r == READWRITE && cycle_r == '0) begin
            dout_r <= ram_dout_i;
        end
    end

    // Chip select on the rising edge, half a cycle ahead of the macro clock
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            csb_r <= 1'b1;
        end else begin
            case (state_r)
                ACTIVATE: csb_r <= 1'b0;
                ACK:      csb_r <= 1'b1;
                default:  csb_r <= csb_r;
            endcase
        end
    end

    // Ack only while the strobe is still up
    assign ack       = (state_r == ACK) && req_valid;
    assign rsp_o.ack = ack;
    assign rsp_o.dat = ack ? dout_r : '0;

    // Free running clock while idle, stretched clock during an access
    assign ram_clk_o = (state_r == IDLE) ? wb_clk_i : int_clk_r;
    assign ram_csb_o = csb_r;
    // Active low, never asserted on a ROM bank
    assign ram_web_o = !(req_i.we && !READ_ONLY);

endmodule

// ==== design/sram_macro_pkg.sv ====
package sram_macro_pkg;

    // Word address into one 256-word macro
    typedef logic [7:0] sram_addr_t;

    // Everything driven into one macro except write data
    typedef struct packed {
        logic       clk;
        logic       csb;
        logic       web;
        sram_addr_t addr;
    } sram_ctrl_t;

    // Access sequence of one port control
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        ACTIVATE  = 3'd1,
        PREFETCH  = 3'd2,
        READWRITE = 3'd3,
        ACK       = 3'd4
    } port_state_e;

endpackage

// ==== design/wb_bus_pkg.sv ====
package wb_bus_pkg;

    // Data and byte address as seen on the Wishbone port
    typedef logic [31:0] wb_data_t;
    typedef logic [11:0] wb_addr_t;

    // Region code taken from address bits 11:10
    typedef logic [1:0] wb_region_t;

    // Region map
    localparam wb_region_t ADDR_BANK0_BASE = 2'b00;
    localparam wb_region_t ADDR_BANK1_BASE = 2'b01;
    localparam wb_region_t ADDR_REGS_BASE  = 2'b10;
    localparam wb_region_t ADDR_UNMAPPED   = 2'b11;

    // Host request, held stable by the host until ack
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    // Slave response, dat is zero whenever ack is low
    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

endpackage
